// File: hdl/audio_pkg.sv
package audio_pkg;

  // width of one audio sample
  // the pwm duty and the decimator count share it
  localparam int sample_bits = 8;

  // one decimated sample, reused as pwm duty
  typedef logic [sample_bits-1:0] sample_t;

  // microphone clocks in one sample window
  // also the largest value a sample can reach
  localparam int window_bits = 255;

  // record / playback controller states
  typedef enum logic [1:0] {
    idle,       // waiting for a button
    recording,  // samples go into the fifo
    playing     // samples come out to the pwm
  } ctrl_state_t;

endpackage

// File: hdl/pdm_clock_gen.sv
module pdm_clock_gen
  import audio_pkg::*;
#(
  parameter int mclk_div = 25  // system clocks per mclk half period
)
(
  input  logic clock,
  input  logic reset,
  output logic mclk,        // microphone clock pin
  output logic mclk_rise,   // high in the cycle mclk goes high
  output logic window_end   // every window_bits-th rise
);

  localparam int div_bits = $clog2(mclk_div + 1);  // room for mclk_div - 1

  logic [div_bits-1:0]    div_count;   // counts one half period
  logic [sample_bits-1:0] rise_count;  // rises seen in this window
  logic                   half_done;   // half period elapsed this cycle
  logic                   rising;      // mclk toggles from low to high
  logic                   last_rise;   // this rise closes the window

  assign half_done = (div_count == div_bits'(mclk_div - 1));
  assign rising    = half_done & ~mclk;
  assign last_rise = (rise_count == sample_bits'(window_bits - 1));

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      div_count  <= '0;
      mclk       <= 1'b0;
      mclk_rise  <= 1'b0;
      window_end <= 1'b0;
      rise_count <= '0;
    end
    else
    begin
      mclk_rise  <= rising;              // lines up with the new mclk level
      window_end <= rising & last_rise;  // same cycle as that rise strobe
      if (half_done)
      begin
        div_count <= '0;
        mclk      <= ~mclk;
      end
      else
      begin
        div_count <= div_count + 1'b1;
      end
      if (rising)
      begin
        if (last_rise)
          rise_count <= '0;  // next window starts with the next rise
        else
          rise_count <= rise_count + 1'b1;
      end
    end
  end

endmodule

// File: hdl/pdm_decimator.sv
module pdm_decimator
  import audio_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    mic_data,      // pdm bit stream from the microphone
  input  logic    mclk_rise,     // sample point of mic_data
  input  logic    window_end,    // last rise of the window
  output sample_t sample,        // ones counted over the last window
  output logic    sample_valid   // one cycle, sample is fresh
);

  logic [sample_bits-1:0] ones_count;  // ones so far in this window
  logic [sample_bits-1:0] ones_next;   // count with the current bit added
  logic                   at_max;      // count cannot grow any further

  // box filter, one bit per mic clock
  assign at_max    = (ones_count == sample_bits'(window_bits));
  assign ones_next = (mic_data && !at_max) ? ones_count + 1'b1 : ones_count;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      ones_count   <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= window_end;  // valid with the registered sample
      if (window_end)
        ones_count <= '0;          // restart for the next window
      else if (mclk_rise)
        ones_count <= ones_next;
    end
  end

  // window_end coincides with a rise so the last bit is taken here
  always_ff @(posedge clock)
  begin
    if (window_end)
      sample <= ones_next;  // held until the next window closes
  end

endmodule

// File: hdl/sample_fifo.sv
module sample_fifo
  import audio_pkg::*;
#(
  parameter int addr_bits = 10  // depth is 2**addr_bits
)
(
  input  logic    clock,
  input  logic    reset,
  input  logic    write,  // one cycle strobe
  input  logic    read,   // one cycle strobe
  input  sample_t wdata,
  output sample_t rdata,  // valid the cycle after read
  output logic    full,
  output logic    empty
);

  localparam int depth = 2 ** addr_bits;

  sample_t mem [depth];  // sample storage

  logic [addr_bits-1:0] wr_ptr;   // next slot to write
  logic [addr_bits-1:0] rd_ptr;   // next slot to read
  logic [addr_bits-1:0] wr_succ;
  logic [addr_bits-1:0] rd_succ;
  logic [addr_bits-1:0] wr_next;
  logic [addr_bits-1:0] rd_next;
  logic                 full_next;
  logic                 empty_next;
  logic                 wr_en;    // write that is actually taken
  logic                 rd_en;    // read that is actually taken

  assign wr_en = write & ~full;   // drop writes while full
  assign rd_en = read & ~empty;   // drop reads while empty

  always_ff @(posedge clock)
  begin
    if (wr_en)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clock)
  begin
    if (rd_en)
      rdata <= mem[rd_ptr];
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end
    else
    begin
      wr_ptr <= wr_next;
      rd_ptr <= rd_next;
      full   <= full_next;
      empty  <= empty_next;
    end
  end

  // pointers wrap at depth
  always_comb
  begin
    wr_succ    = wr_ptr + 1'b1;
    rd_succ    = rd_ptr + 1'b1;
    wr_next    = wr_ptr;
    rd_next    = rd_ptr;
    full_next  = full;
    empty_next = empty;
    case ({wr_en, rd_en})
      2'b01:
      begin
        rd_next    = rd_succ;
        full_next  = 1'b0;
        empty_next = (rd_succ == wr_ptr);  // last word just left
      end
      2'b10:
      begin
        wr_next    = wr_succ;
        empty_next = 1'b0;
        full_next  = (wr_succ == rd_ptr);  // writer caught up with reader
      end
      2'b11:
      begin
        wr_next = wr_succ;  // occupancy unchanged
        rd_next = rd_succ;
      end
      default:
      begin
        wr_next = wr_ptr;
      end
    endcase
  end

endmodule

// File: hdl/pwm_player.sv
module pwm_player
  import audio_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    duty_load,  // duty_in is a new sample
  input  sample_t duty_in,
  input  logic    enable,     // amplifier is on
  output logic    amp_pwm     // to the amplifier input
);

  logic [sample_bits-1:0] pwm_count;     // free running, 256 clocks per period
  sample_t                duty_pending;  // latest loaded sample
  sample_t                duty_active;   // duty of the running period
  logic                   wrap;          // last cycle of the period

  assign wrap = (pwm_count == '1);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      pwm_count    <= '0;
      duty_pending <= '0;
      duty_active  <= '0;
    end
    else
    begin
      pwm_count <= pwm_count + 1'b1;  // rolls over by itself
      if (duty_load)
        duty_pending <= duty_in;
      if (wrap)
        duty_active <= duty_pending;  // duty only moves between periods
    end
  end

  // duty 255 gives 255 high cycles out of 256
  assign amp_pwm = enable & (pwm_count < duty_active);

endmodule

// File: hdl/playback_control.sv
module playback_control
  import audio_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic record_button,  // raw push button
  input  logic play_button,    // raw push button
  input  logic sample_valid,
  input  logic window_end,
  input  logic fifo_full,
  input  logic fifo_empty,
  output logic fifo_write,
  output logic fifo_read,
  output logic duty_load,      // rdata is fresh for the pwm
  output logic amp_sd,         // amplifier enable
  output logic led_recording,
  output logic led_playing
);

  ctrl_state_t state;
  ctrl_state_t state_next;

  logic rec_sync1;    // first synchronizer stage
  logic rec_sync2;
  logic rec_last;     // previous synchronized level
  logic play_sync1;
  logic play_sync2;
  logic play_last;
  logic rec_release;  // one cycle at the button release
  logic play_release;

  // act on the falling edge only, one pulse per press
  assign rec_release  = rec_last & ~rec_sync2;
  assign play_release = play_last & ~play_sync2;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      rec_sync1  <= 1'b0;
      rec_sync2  <= 1'b0;
      rec_last   <= 1'b0;
      play_sync1 <= 1'b0;
      play_sync2 <= 1'b0;
      play_last  <= 1'b0;
      state      <= idle;
      fifo_write <= 1'b0;
      fifo_read  <= 1'b0;
      duty_load  <= 1'b0;
    end
    else
    begin
      rec_sync1  <= record_button;
      rec_sync2  <= rec_sync1;
      rec_last   <= rec_sync2;
      play_sync1 <= play_button;
      play_sync2 <= play_sync1;
      play_last  <= play_sync2;
      state      <= state_next;
      fifo_write <= (state == recording) & sample_valid;  // sample still held
      fifo_read  <= (state == playing) & window_end & ~fifo_empty;
      duty_load  <= fifo_read;  // rdata shows up now
    end
  end

  always_comb
  begin
    state_next = state;
    case (state)
      idle:
      begin
        if (rec_release)
          state_next = recording;
        else if (play_release && !fifo_empty)
          state_next = playing;  // nothing to play otherwise
      end
      recording:
      begin
        if (rec_release || fifo_full)
          state_next = idle;     // stopped by hand or buffer is full
      end
      playing:
      begin
        if (window_end && fifo_empty)
          state_next = idle;     // one window after the last read
      end
      default:
      begin
        state_next = idle;
      end
    endcase
  end

  assign led_recording = (state == recording);
  assign led_playing   = (state == playing);
  assign amp_sd        = (state == playing);

endmodule

// File: hdl/audio_loop_top.sv
module audio_loop_top
  import audio_pkg::*;
#(
  parameter int addr_bits = 10,  // fifo holds 2**addr_bits samples
  parameter int mclk_div  = 25   // system clocks per mclk half period
)
(
  input  logic clock,
  input  logic reset,
  input  logic mic_data,       // pdm data from the microphone
  input  logic record_button,
  input  logic play_button,
  output logic mclk,           // microphone clock
  output logic amp_pwm,        // audio out to the amplifier
  output logic amp_sd,         // amplifier shutdown pin, high is on
  output logic led_recording,
  output logic led_playing,
  output logic fifo_full,
  output logic fifo_empty
);

  logic    mclk_rise;
  logic    window_end;   // one sample period elapsed
  sample_t sample;       // decimator output
  logic    sample_valid;
  logic    fifo_write;
  logic    fifo_read;
  sample_t rdata;        // played sample
  logic    duty_load;

  // shared timebase for recording and playback
  pdm_clock_gen #(
    .mclk_div   (mclk_div)
  ) u_clock_gen (
    .clock      (clock),
    .reset      (reset),
    .mclk       (mclk),
    .mclk_rise  (mclk_rise),
    .window_end (window_end)
  );

  pdm_decimator u_decimator (
    .clock        (clock),
    .reset        (reset),
    .mic_data     (mic_data),
    .mclk_rise    (mclk_rise),
    .window_end   (window_end),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  sample_fifo #(
    .addr_bits (addr_bits)
  ) u_fifo (
    .clock     (clock),
    .reset     (reset),
    .write     (fifo_write),
    .read      (fifo_read),
    .wdata     (sample),
    .rdata     (rdata),
    .full      (fifo_full),
    .empty     (fifo_empty)
  );

  pwm_player u_pwm (
    .clock     (clock),
    .reset     (reset),
    .duty_load (duty_load),
    .duty_in   (rdata),
    .enable    (amp_sd),     // silent unless playing
    .amp_pwm   (amp_pwm)
  );

  playback_control u_control (
    .clock         (clock),
    .reset         (reset),
    .record_button (record_button),
    .play_button   (play_button),
    .sample_valid  (sample_valid),
    .window_end    (window_end),
    .fifo_full     (fifo_full),
    .fifo_empty    (fifo_empty),
    .fifo_write    (fifo_write),
    .fifo_read     (fifo_read),
    .duty_load     (duty_load),
    .amp_sd        (amp_sd),
    .led_recording (led_recording),
    .led_playing   (led_playing)
  );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen
(
  output logic clock
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
    clock = 1'b0;

  always
    #4 clock = ~clock;  // 8 ns period

endmodule

// File: testbench/audio_loop_asserts.sv
module audio_loop_asserts
(
  input logic clock,
  input logic reset,
  input logic fifo_full,
  input logic fifo_empty,
  input logic amp_sd,
  input logic amp_pwm,
  input logic led_playing
);

  timeunit 1ns;
  timeprecision 100ps;

  // occupancy cannot be zero and depth at once
  flags_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(fifo_full && fifo_empty))
    else $error("fifo_full and fifo_empty high together");

  amp_follows_led: assert property (@(posedge clock) disable iff (reset)
    amp_sd == led_playing)
    else $error("amp_sd differs from led_playing");

  // amplifier off means a silent output
  pwm_quiet: assert property (@(posedge clock) disable iff (reset)
    !amp_sd |-> !amp_pwm)
    else $error("amp_pwm high while amp_sd low");

endmodule

bind audio_loop_top audio_loop_asserts u_asserts (
  .clock       (clock),
  .reset       (reset),
  .fifo_full   (fifo_full),
  .fifo_empty  (fifo_empty),
  .amp_sd      (amp_sd),
  .amp_pwm     (amp_pwm),
  .led_playing (led_playing)
);

// File: testbench/audio_loop_tb.sv
module audio_loop_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int  addr_bits   = 3;
  localparam int  mclk_div    = 2;
  localparam int  window_clks = 2 * mclk_div * 255;  // system clocks per sample window
  localparam int  num_windows = 170;                 // all tests with margin
  localparam longint watchdog_ns = longint'(num_windows) * 4 * mclk_div * 255 * 8;

  logic clock;
  logic reset;
  logic mic_data;
  logic record_button;
  logic play_button;
  logic mclk;
  logic amp_pwm;
  logic amp_sd;
  logic led_recording;
  logic led_playing;
  logic fifo_full;
  logic fifo_empty;

  int          cyc;          // mirrors the free running pwm counter
  int          rise_total;   // mclk rises since reset
  int          mic_k;        // one high bit every mic_k rises, 0 is never
  int          error_count;
  logic        mclk_last;    // mclk level one clock earlier
  int          mclk_gap;     // clocks since the last mclk rise
  logic [31:0] lfsr_state;
  int          divisors [9] = '{1, 3, 5, 15, 17, 51, 85, 255, 0};

  tb_clock_gen u_clock (.clock(clock));

  audio_loop_top #(
    .addr_bits (addr_bits),
    .mclk_div  (mclk_div)
  ) UUT (
    .clock         (clock),
    .reset         (reset),
    .mic_data      (mic_data),
    .record_button (record_button),
    .play_button   (play_button),
    .mclk          (mclk),
    .amp_pwm       (amp_pwm),
    .amp_sd        (amp_sd),
    .led_recording (led_recording),
    .led_playing   (led_playing),
    .fifo_full     (fifo_full),
    .fifo_empty    (fifo_empty)
  );

  always @(posedge clock or posedge reset)
  begin
    if (reset)
      cyc <= 0;
    else
      cyc <= cyc + 1;  // same edges as the pwm counter
  end

  // microphone model, one bit per rise of the mclk pin
  always @(posedge clock)
  begin
    #1;
    mclk_gap = mclk_gap + 1;
    if (mclk && !mclk_last)
    begin
      if (rise_total > 0)
      begin
        assert (mclk_gap == 2 * mclk_div)
          else value_error("mclk period", mclk_gap, 2 * mclk_div);
      end
      mclk_gap   = 0;
      rise_total = rise_total + 1;
      mic_data   = (mic_k != 0) && (rise_total % mic_k == 0);
    end
    mclk_last = mclk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'ha300_0000;
    else
      return s >> 1;
  endfunction

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      value      = (value << 1) | int'(lfsr_state[0]);  // one step per bit
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic value_error(input string name, input int got, input int exp);
    error_count++;
    $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("TESTS FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic text_error(input string msg);
    error_count++;
    $display("** Error: %s", msg);
    $display("TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  // hold the button 4 cycles then release
  task automatic press(input bit play);
    @(posedge clock);
    #1;
    if (play)
      play_button = 1'b1;
    else
      record_button = 1'b1;
    repeat (4) @(posedge clock);
    #1;
    play_button   = 1'b0;
    record_button = 1'b0;
  endtask

  task automatic measure_period(output int high_count, output bit whole, output int start);
    high_count = 0;
    whole      = 1'b1;
    do @(negedge clock); while (cyc[7:0] != 0);
    start = cyc;
    for (int i = 0; i < 256; i++)
    begin
      if (i > 0)
        @(negedge clock);
      if (!amp_sd)
        whole = 1'b0;
      if (amp_pwm)
        high_count++;
    end
  endtask

  task automatic check_reset_state();
    repeat (300) @(negedge clock)
    begin
      assert (amp_pwm == 1'b0) else value_error("amp_pwm", amp_pwm, 0);
      assert (amp_sd == 1'b0) else value_error("amp_sd", amp_sd, 0);
    end
    assert (!led_recording) else value_error("led_recording", led_recording, 0);
    assert (!led_playing) else value_error("led_playing", led_playing, 0);
    assert (!fifo_full) else value_error("fifo_full", fifo_full, 0);
    assert (fifo_empty) else value_error("fifo_empty", fifo_empty, 1);
  endtask

  task automatic play_when_empty();
    press(1'b1);
    repeat (3 * window_clks) @(negedge clock)
      assert (!led_playing) else text_error("play started with an empty fifo");
  endtask

  task automatic record_round(input int k);
    int t;
    mic_k = k;
    repeat (window_clks + 80) @(posedge clock);  // flush the window holding the change
    press(1'b0);
    t = 0;
    while (!led_recording && t < 10)
    begin
      @(negedge clock);
      t++;
    end
    assert (led_recording) else text_error("recording did not start");
    t = 0;
    while (fifo_empty && t < 2 * window_clks + 20)
    begin
      @(negedge clock);
      t++;
    end
    assert (!fifo_empty) else text_error("no sample written after a window");
    t = 0;
    while (!fifo_full && t < 9 * window_clks)
    begin
      @(negedge clock);
      t++;
      assert (led_recording) else text_error("recording stopped before full");
    end
    assert (fifo_full) else text_error("fifo did not fill");
    repeat (3) @(negedge clock);
    assert (!led_recording) else value_error("led_recording", led_recording, 0);
  endtask

  task automatic play_round(input int k);
    int t;
    int high;
    int start;
    int begin_cyc;
    int checked;
    int expected;
    bit whole;
    expected = (k == 0) ? 0 : 255 / k;
    checked  = 0;
    press(1'b1);
    t = 0;
    while (!amp_sd && t < 10)
    begin
      @(negedge clock);
      t++;
    end
    assert (amp_sd) else text_error("playback did not start");
    begin_cyc = cyc;
    whole     = 1'b1;
    t         = 0;
    while (whole && t < 60)
    begin
      measure_period(high, whole, start);
      t++;
      // first load lands within one window plus one pwm period
      if (whole && start - begin_cyc >= window_clks + 300)
      begin
        checked++;
        assert (high == expected) else value_error("amp_pwm high count", high, expected);
      end
    end
    assert (!amp_sd) else text_error("playback did not end");
    assert (fifo_empty) else value_error("fifo_empty", fifo_empty, 1);
    assert (cyc - begin_cyc >= 8 * window_clks && cyc - begin_cyc <= 9 * window_clks + 300)
      else text_error("playback length does not match 8 samples");
    assert (checked >= 20) else text_error("too few pwm periods measured");
  endtask

  task automatic short_record();
    int t;
    t = 0;
    while (rise_total % 255 != 1 && t < window_clks + 20)
    begin
      @(negedge clock);
      t++;
    end
    press(1'b0);  // just after a window end
    repeat (4) @(negedge clock);
    assert (led_recording) else value_error("led_recording", led_recording, 1);
    press(1'b0);
    repeat (4) @(negedge clock);
    assert (!led_recording) else value_error("led_recording", led_recording, 0);
    repeat (window_clks + 20) @(negedge clock);
    assert (fifo_empty) else value_error("fifo_empty", fifo_empty, 1);
  endtask

  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial
  begin
    int idx;
    int k;
    reset         = 1'b1;
    mic_data      = 1'b0;
    record_button = 1'b0;
    play_button   = 1'b0;
    rise_total    = 0;
    mic_k         = 0;
    error_count   = 0;
    mclk_last     = 1'b0;
    mclk_gap      = 0;
    lfsr_state    = 32'hcfce96d6;
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;
    check_reset_state();
    play_when_empty();
    record_round(15);
    play_round(15);
    short_record();
    record_round(1);
    play_round(1);
    repeat (4)
    begin
      take_bits(4, idx);
      k = divisors[idx % 9];
      record_round(k);
      play_round(k);
    end
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: files.f
hdl/audio_pkg.sv
hdl/pdm_clock_gen.sv
hdl/pdm_decimator.sv
hdl/sample_fifo.sv
hdl/pwm_player.sv
hdl/playback_control.sv
hdl/audio_loop_top.sv
testbench/tb_clock_gen.sv
testbench/audio_loop_asserts.sv
testbench/audio_loop_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the audio loop testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module audio_loop_tb \
  -o audio_loop_sim > build.log 2>&1 \
  && ./obj_dir/audio_loop_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
